/* src/io_map_pkg.sv */
// bus map constants; offsets assume word-aligned accesses on a 5-bit byte address
`default_nettype none

package io_map_pkg;

    // axi4-lite bus shape
    localparam int addr_width = 5;
    localparam int data_width = 32;

    // register byte offsets
    localparam logic [addr_width-1:0] reg_status   = 5'h00;
    localparam logic [addr_width-1:0] reg_kbd_data = 5'h04;
    localparam logic [addr_width-1:0] reg_led      = 5'h08;
    localparam logic [addr_width-1:0] reg_seg      = 5'h0C;
    localparam logic [addr_width-1:0] reg_swt      = 5'h10;

    // response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // board i/o widths
    localparam int led_width = 8;
    localparam int swt_width = 8;
    localparam int seg_width = 32;

    // system cycles per half period of the segment clock
    localparam int seg_div = 8;

endpackage

`default_nettype wire

/* src/ps2_pkg.sv */
// keyboard path constants; fifo_count_width must hold fifo_depth itself
`default_nettype none

package ps2_pkg;

    // one scan code per frame
    localparam int scan_width = 8;

    // start, 8 data, parity, stop
    localparam int frame_bits = 11;

    // scan-code buffer
    localparam int fifo_depth       = 8;
    localparam int fifo_count_width = 4;

    // flops per input synchronizer
    localparam int sync_stages = 2;

endpackage

`default_nettype wire

/* src/ps2_rx.sv */
// device-to-host frames only; no frame timeout, so a glitch mid-frame slips alignment
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
    input  wire                              clk200m,
    input  wire                              reset,
    input  wire                              ps2_clk,
    input  wire                              ps2_data,
    output logic                             scan_valid,
    output logic [ps2_pkg::scan_width-1:0]   scan_code
);

    localparam int cnt_w = $clog2(ps2_pkg::frame_bits);

    logic [ps2_pkg::sync_stages-1:0] clk_sync;
    logic [ps2_pkg::sync_stages-1:0] data_sync;
    logic                            clk_s;
    logic                            data_s;
    logic                            clk_prev;
    logic                            fall;
    logic [cnt_w-1:0]                bit_cnt;
    logic                            last_bit;
    logic [ps2_pkg::frame_bits-1:0]  shift_reg;
    logic [ps2_pkg::frame_bits-1:0]  frame;
    logic                            frame_ok;

    assign clk_s  = clk_sync[ps2_pkg::sync_stages-1];
    assign data_s = data_sync[ps2_pkg::sync_stages-1];
    assign fall   = clk_prev & ~clk_s;
    assign last_bit = (bit_cnt == cnt_w'(ps2_pkg::frame_bits - 1));

    // frame as it looks once the current bit is in, lsb first on the wire
    assign frame = {data_s, shift_reg[ps2_pkg::frame_bits-1:1]};

    // start low, stop high, odd parity over data plus parity bit
    assign frame_ok = ~frame[0] & frame[ps2_pkg::frame_bits-1]
                      & (^frame[ps2_pkg::frame_bits-2:1]);

    always_ff @(posedge clk200m) begin
        if (reset) begin
            // lines idle high
            clk_sync   <= '1;
            data_sync  <= '1;
            clk_prev   <= 1'b1;
            bit_cnt    <= '0;
            scan_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[ps2_pkg::sync_stages-2:0], ps2_clk};
            data_sync  <= {data_sync[ps2_pkg::sync_stages-2:0], ps2_data};
            clk_prev   <= clk_s;
            scan_valid <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt    <= '0;
                    // bad frames just vanish
                    scan_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // data path, sampled on each falling ps2 clock
    always_ff @(posedge clk200m) begin
        if (fall) begin
            shift_reg <= frame;
            if (last_bit) begin
                scan_code <= frame[ps2_pkg::scan_width:1];
            end
        end
    end

endmodule

`default_nettype wire

/* src/scan_fifo.sv */
// writes into a full buffer are lost, even when a pop lands on the same cycle
`timescale 1ns/1ps
`default_nettype none

module scan_fifo (
    input  wire                                  clk200m,
    input  wire                                  reset,
    input  wire                                  wr_en,
    input  wire  [ps2_pkg::scan_width-1:0]       wr_data,
    input  wire                                  rd_en,
    output logic [ps2_pkg::scan_width-1:0]       rd_data,
    output logic [ps2_pkg::fifo_count_width-1:0] count,
    output logic                                 overflow,
    input  wire                                  ovf_clr
);

    localparam int ptr_w = $clog2(ps2_pkg::fifo_depth);

    logic [ps2_pkg::scan_width-1:0] mem [ps2_pkg::fifo_depth];
    logic [ptr_w-1:0]               wr_ptr;
    logic [ptr_w-1:0]               rd_ptr;
    logic                           full;
    logic                           do_wr;
    logic                           do_rd;

    assign full  = (count == ps2_pkg::fifo_count_width'(ps2_pkg::fifo_depth));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & (count != '0);

    // head shown straight from the array
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk200m) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk200m) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // pointers wrap on power-of-two depth
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            // sticky flag where a fresh drop beats the clear
            if (wr_en && full) begin
                overflow <= 1'b1;
            end else if (ovf_clr) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/io_axil_regs.sv */
// master must hold awvalid and wvalid together until ready; one transfer in flight per side
`timescale 1ns/1ps
`default_nettype none

module io_axil_regs (
    input  wire                                  clk200m,
    input  wire                                  reset,
    input  wire  [io_map_pkg::addr_width-1:0]    s_axil_awaddr,
    input  wire                                  s_axil_awvalid,
    output logic                                 s_axil_awready,
    input  wire  [io_map_pkg::data_width-1:0]    s_axil_wdata,
    input  wire  [io_map_pkg::data_width/8-1:0]  s_axil_wstrb,
    input  wire                                  s_axil_wvalid,
    output logic                                 s_axil_wready,
    output logic [1:0]                           s_axil_bresp,
    output logic                                 s_axil_bvalid,
    input  wire                                  s_axil_bready,
    input  wire  [io_map_pkg::addr_width-1:0]    s_axil_araddr,
    input  wire                                  s_axil_arvalid,
    output logic                                 s_axil_arready,
    output logic [io_map_pkg::data_width-1:0]    s_axil_rdata,
    output logic [1:0]                           s_axil_rresp,
    output logic                                 s_axil_rvalid,
    input  wire                                  s_axil_rready,
    output logic                                 fifo_rd_en,
    input  wire  [ps2_pkg::scan_width-1:0]       fifo_rd_data,
    input  wire  [ps2_pkg::fifo_count_width-1:0] fifo_count,
    input  wire                                  fifo_overflow,
    output logic                                 fifo_ovf_clr,
    input  wire  [io_map_pkg::swt_width-1:0]     swt,
    output logic [io_map_pkg::led_width-1:0]     leds,
    output logic                                 seg_load,
    output logic [io_map_pkg::seg_width-1:0]     seg_value
);

    logic [io_map_pkg::swt_width-1:0]  swt_sync [ps2_pkg::sync_stages];
    logic                              wr_fire;
    logic                              rd_fire;
    logic                              not_empty;
    logic [io_map_pkg::data_width-1:0] rd_word;

    function automatic logic is_mapped(input logic [io_map_pkg::addr_width-1:0] addr);
        return addr inside {io_map_pkg::reg_status, io_map_pkg::reg_kbd_data,
                            io_map_pkg::reg_led, io_map_pkg::reg_seg, io_map_pkg::reg_swt};
    endfunction

    // ready is up for exactly the handshake cycle
    assign wr_fire   = s_axil_awready & s_axil_awvalid & s_axil_wvalid;
    assign rd_fire   = s_axil_arready & s_axil_arvalid;
    assign not_empty = (fifo_count != '0);

    // pop and clear fire on the handshake itself
    assign fifo_rd_en = rd_fire & (s_axil_araddr == io_map_pkg::reg_kbd_data) & not_empty;
    assign fifo_ovf_clr = wr_fire & (s_axil_awaddr == io_map_pkg::reg_status)
                          & s_axil_wstrb[0] & s_axil_wdata[1];

    // read mux
    always_comb begin
        rd_word = '0;
        case (s_axil_araddr)
            io_map_pkg::reg_status: begin
                rd_word[0] = not_empty;
                rd_word[1] = fifo_overflow;
                rd_word[4 +: ps2_pkg::fifo_count_width] = fifo_count;
            end
            io_map_pkg::reg_kbd_data: begin
                // empty read stays all zero
                if (not_empty) begin
                    rd_word[ps2_pkg::scan_width-1:0] = fifo_rd_data;
                    rd_word[8] = 1'b1;
                end
            end
            io_map_pkg::reg_led: rd_word[io_map_pkg::led_width-1:0] = leds;
            io_map_pkg::reg_seg: rd_word = seg_value;
            io_map_pkg::reg_swt: begin
                rd_word[io_map_pkg::swt_width-1:0] = swt_sync[ps2_pkg::sync_stages-1];
            end
            default: rd_word = '0;
        endcase
    end

    // switch synchronizer
    always_ff @(posedge clk200m) begin
        swt_sync[0] <= swt;
        for (int i = 1; i < ps2_pkg::sync_stages; i++) begin
            swt_sync[i] <= swt_sync[i-1];
        end
    end

    always_ff @(posedge clk200m) begin
        if (reset) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            leds           <= '0;
            seg_value      <= '0;
            seg_load       <= 1'b0;
        end else begin
            // accept only with no response pending
            s_axil_awready <= s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid & ~s_axil_awready;
            s_axil_wready  <= s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid & ~s_axil_awready;
            s_axil_arready <= s_axil_arvalid & ~s_axil_rvalid & ~s_axil_arready;
            seg_load <= 1'b0;

            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
                if (s_axil_awaddr == io_map_pkg::reg_led && s_axil_wstrb[0]) begin
                    leds <= s_axil_wdata[io_map_pkg::led_width-1:0];
                end
                if (s_axil_awaddr == io_map_pkg::reg_seg) begin
                    for (int b = 0; b < io_map_pkg::seg_width / 8; b++) begin
                        if (s_axil_wstrb[b]) begin
                            seg_value[b*8 +: 8] <= s_axil_wdata[b*8 +: 8];
                        end
                    end
                    // shifter picks up the new value next cycle
                    seg_load <= 1'b1;
                end
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end

            if (rd_fire) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clk200m) begin
        if (wr_fire) begin
            s_axil_bresp <= is_mapped(s_axil_awaddr) ? io_map_pkg::resp_okay
                                                     : io_map_pkg::resp_slverr;
        end
        if (rd_fire) begin
            s_axil_rdata <= rd_word;
            s_axil_rresp <= is_mapped(s_axil_araddr) ? io_map_pkg::resp_okay
                                                     : io_map_pkg::resp_slverr;
        end
    end

endmodule

`default_nettype wire

/* src/seg_shift.sv */
// a load during a shift restarts from the new value; no character decoding is done here
`timescale 1ns/1ps
`default_nettype none

module seg_shift (
    input  wire                              clk200m,
    input  wire                              reset,
    input  wire                              seg_load,
    input  wire  [io_map_pkg::seg_width-1:0] seg_value,
    output logic                             seg_clk,
    output logic                             seg_clrn,
    output logic                             seg_data,
    output logic                             seg_en
);

    localparam int div_w = $clog2(io_map_pkg::seg_div);
    localparam int bit_w = $clog2(io_map_pkg::seg_width);

    logic [div_w-1:0]                div_cnt;
    logic [bit_w-1:0]                bit_cnt;
    logic [io_map_pkg::seg_width-1:0] shift_reg;
    logic                            busy;
    logic                            half_done;

    assign half_done = (div_cnt == div_w'(io_map_pkg::seg_div - 1));

    // msb always on the pin
    assign seg_data = shift_reg[io_map_pkg::seg_width-1];

    always_ff @(posedge clk200m) begin
        if (reset) begin
            seg_clrn <= 1'b0;
            seg_clk  <= 1'b0;
            seg_en   <= 1'b1;
            busy     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            seg_clrn <= 1'b1;
            if (seg_load) begin
                // first bit set up while clock is low
                busy    <= 1'b1;
                seg_en  <= 1'b0;
                seg_clk <= 1'b0;
                div_cnt <= '0;
                bit_cnt <= '0;
            end else if (busy) begin
                div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                if (half_done) begin
                    seg_clk <= ~seg_clk;
                    // falling edge ends a bit
                    if (seg_clk) begin
                        if (bit_cnt == bit_w'(io_map_pkg::seg_width - 1)) begin
                            busy   <= 1'b0;
                            seg_en <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // data only moves with the clock low
    always_ff @(posedge clk200m) begin
        if (seg_load) begin
            shift_reg <= seg_value;
        end else if (busy && half_done && seg_clk) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

`default_nettype wire

/* src/io_top.sv */
// single clock domain; the cpu sits outside as the axi4-lite master
`timescale 1ns/1ps
`default_nettype none

module io_top (
    input  wire                                 clk200m,
    input  wire                                 reset,
    input  wire                                 ps2_clk,
    input  wire                                 ps2_data,
    input  wire  [io_map_pkg::swt_width-1:0]    swt,
    output logic [io_map_pkg::led_width-1:0]    leds,
    output logic                                seg_clk,
    output logic                                seg_clrn,
    output logic                                seg_data,
    output logic                                seg_en,
    input  wire  [io_map_pkg::addr_width-1:0]   s_axil_awaddr,
    input  wire                                 s_axil_awvalid,
    output logic                                s_axil_awready,
    input  wire  [io_map_pkg::data_width-1:0]   s_axil_wdata,
    input  wire  [io_map_pkg::data_width/8-1:0] s_axil_wstrb,
    input  wire                                 s_axil_wvalid,
    output logic                                s_axil_wready,
    output logic [1:0]                          s_axil_bresp,
    output logic                                s_axil_bvalid,
    input  wire                                 s_axil_bready,
    input  wire  [io_map_pkg::addr_width-1:0]   s_axil_araddr,
    input  wire                                 s_axil_arvalid,
    output logic                                s_axil_arready,
    output logic [io_map_pkg::data_width-1:0]   s_axil_rdata,
    output logic [1:0]                          s_axil_rresp,
    output logic                                s_axil_rvalid,
    input  wire                                 s_axil_rready
);

    // keyboard path
    logic                                 scan_valid;
    logic [ps2_pkg::scan_width-1:0]       scan_code;
    logic                                 fifo_rd_en;
    logic [ps2_pkg::scan_width-1:0]       fifo_rd_data;
    logic [ps2_pkg::fifo_count_width-1:0] fifo_count;
    logic                                 fifo_overflow;
    logic                                 fifo_ovf_clr;
    // display path
    logic                                 seg_load;
    logic [io_map_pkg::seg_width-1:0]     seg_value;

    ps2_rx u_ps2_rx (
        .clk200m    (clk200m),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan_valid (scan_valid),
        .scan_code  (scan_code)
    );

    scan_fifo u_scan_fifo (
        .clk200m  (clk200m),
        .reset    (reset),
        .wr_en    (scan_valid),
        .wr_data  (scan_code),
        .rd_en    (fifo_rd_en),
        .rd_data  (fifo_rd_data),
        .count    (fifo_count),
        .overflow (fifo_overflow),
        .ovf_clr  (fifo_ovf_clr)
    );

    io_axil_regs u_io_axil_regs (
        .clk200m        (clk200m),
        .reset          (reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_rd_data   (fifo_rd_data),
        .fifo_count     (fifo_count),
        .fifo_overflow  (fifo_overflow),
        .fifo_ovf_clr   (fifo_ovf_clr),
        .swt            (swt),
        .leds           (leds),
        .seg_load       (seg_load),
        .seg_value      (seg_value)
    );

    seg_shift u_seg_shift (
        .clk200m   (clk200m),
        .reset     (reset),
        .seg_load  (seg_load),
        .seg_value (seg_value),
        .seg_clk   (seg_clk),
        .seg_clrn  (seg_clrn),
        .seg_data  (seg_data),
        .seg_en    (seg_en)
    );

endmodule

`default_nettype wire

/* tests/tb_io_top.sv */
// one bus transfer at a time and ps2 frames never overlap a bus access; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_io_top;

    localparam int clk_ns     = 10;
    localparam int ps2_half   = 40;
    localparam int num_frames = 18;
    // frames, then segment shifts, then margin
    localparam int timeout_cycles = num_frames * ps2_pkg::frame_bits * 2 * ps2_half
                                    + 40 * 32 * 16 + 5000;

    logic                                 clk200m;
    logic                                 reset;
    logic                                 ps2_clk;
    logic                                 ps2_data;
    logic [io_map_pkg::swt_width-1:0]     swt;
    logic [io_map_pkg::led_width-1:0]     leds;
    logic                                 seg_clk;
    logic                                 seg_clrn;
    logic                                 seg_data;
    logic                                 seg_en;
    logic [io_map_pkg::addr_width-1:0]    s_axil_awaddr;
    logic                                 s_axil_awvalid;
    logic                                 s_axil_awready;
    logic [io_map_pkg::data_width-1:0]    s_axil_wdata;
    logic [io_map_pkg::data_width/8-1:0]  s_axil_wstrb;
    logic                                 s_axil_wvalid;
    logic                                 s_axil_wready;
    logic [1:0]                           s_axil_bresp;
    logic                                 s_axil_bvalid;
    logic                                 s_axil_bready;
    logic [io_map_pkg::addr_width-1:0]    s_axil_araddr;
    logic                                 s_axil_arvalid;
    logic                                 s_axil_arready;
    logic [io_map_pkg::data_width-1:0]    s_axil_rdata;
    logic [1:0]                           s_axil_rresp;
    logic                                 s_axil_rvalid;
    logic                                 s_axil_rready;

    // reference model state
    logic [7:0]  exp_codes[$];
    logic        exp_ovf;
    logic [7:0]  exp_led;
    logic [7:0]  exp_swt;
    logic [31:0] exp_seg;
    int          seg_shifts;
    int          cycles;

    io_top u_io_top (.*);

    initial begin
        clk200m = 1'b0;
        forever #(clk_ns / 2) clk200m = ~clk200m;
    end

    // all stimulus moves 1 ns after the rising edge
    task automatic step();
        @(posedge clk200m);
        #1;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // device-to-host frame sent lsb first with data moving while ps2_clk is high
    task automatic ps2_send(input logic [7:0] code, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < ps2_pkg::frame_bits; i++) begin
            ps2_data = frame[i];
            repeat (ps2_half) step();
            ps2_clk = 1'b0;
            repeat (ps2_half) step();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (ps2_half) step();
        // a full buffer drops the code in the model too
        if (!bad_parity) begin
            if (exp_codes.size() < ps2_pkg::fifo_depth) begin
                exp_codes.push_back(code);
            end else begin
                exp_ovf = 1'b1;
            end
        end
    endtask

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        step();
        while (!(s_axil_awready && s_axil_wready)) step();
        // handshake on the coming edge
        step();
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid) step();
        // response must hold under back-pressure
        repeat ($urandom_range(3)) begin
            step();
            check(32'(s_axil_bvalid), 32'd1, "bvalid held under back-pressure");
        end
        resp = s_axil_bresp;
        s_axil_bready = 1'b1;
        step();
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        step();
        while (!s_axil_arready) step();
        step();
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid) step();
        repeat ($urandom_range(3)) begin
            step();
            check(32'(s_axil_rvalid), 32'd1, "rvalid held under back-pressure");
        end
        data = s_axil_rdata;
        resp = s_axil_rresp;
        s_axil_rready = 1'b1;
        step();
        s_axil_rready = 1'b0;
    endtask

    // expected read data from the register map rules
    function automatic logic [31:0] expected_read(input logic [4:0] addr);
        logic [31:0] word;
        word = '0;
        case (addr)
            io_map_pkg::reg_status: begin
                word[0]   = (exp_codes.size() != 0);
                word[1]   = exp_ovf;
                word[7:4] = 4'(exp_codes.size());
            end
            io_map_pkg::reg_kbd_data: begin
                if (exp_codes.size() != 0) begin
                    word[8:0] = {1'b1, exp_codes[0]};
                end
            end
            io_map_pkg::reg_led: word[7:0] = exp_led;
            io_map_pkg::reg_seg: word = exp_seg;
            io_map_pkg::reg_swt: word[7:0] = exp_swt;
            default: word = '0;
        endcase
        return word;
    endfunction

    // kbd_data read pops the model too
    task automatic read_check(input logic [4:0] addr, input string what);
        logic [31:0] expected;
        logic [31:0] data;
        logic [1:0]  resp;
        expected = expected_read(addr);
        axil_read(addr, data, resp);
        check(data, expected, what);
        check(32'(resp), 32'(io_map_pkg::resp_okay), {what, " response"});
        if (addr == io_map_pkg::reg_kbd_data && exp_codes.size() != 0) begin
            void'(exp_codes.pop_front());
        end
    endtask

    task automatic write_check(input logic [4:0] addr, input logic [31:0] data,
                               input string what);
        logic [1:0] resp;
        axil_write(addr, data, 4'hF, resp);
        check(32'(resp), 32'(io_map_pkg::resp_okay), what);
    endtask

    // rebuilds each shifted word from the serial pins
    initial begin : seg_monitor
        logic [31:0] word;
        time         last_rise;
        forever begin
            @(negedge seg_en);
            word = '0;
            for (int i = 0; i < io_map_pkg::seg_width; i++) begin
                @(posedge seg_clk);
                check(32'(seg_en), 32'd0, "seg_en low through the shift");
                if (i > 0) begin
                    check(32'($time - last_rise), 32'(2 * io_map_pkg::seg_div * clk_ns),
                          "segment bit period");
                end
                last_rise = $time;
                word = {word[30:0], seg_data};
            end
            @(posedge seg_en);
            check(word, exp_seg, "segment word from serial pins");
            seg_shifts++;
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk200m);
            cycles++;
        end
        $display("error: the test timed out after %0d cycles", cycles);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin : main
        logic [31:0] data;
        logic [1:0]  resp;
        int          shifts_before;
        void'($urandom(80898));
        reset          = 1'b1;
        ps2_clk        = 1'b1;
        ps2_data       = 1'b1;
        swt            = '0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        exp_ovf        = 1'b0;
        exp_led        = '0;
        exp_swt        = '0;
        exp_seg        = '0;
        seg_shifts     = 0;
        repeat (5) step();
        check(32'(seg_clrn), 32'd0, "seg_clrn low in reset");
        reset = 1'b0;
        step();
        check(32'(seg_clrn), 32'd1, "seg_clrn high after reset");
        check(32'({seg_clk, seg_en}), 32'b01, "segment pins idle");
        check(32'(leds), 32'd0, "leds after reset");
        check(32'({s_axil_awready, s_axil_wready, s_axil_bvalid, s_axil_arready,
                   s_axil_rvalid}), 32'd0, "bus outputs after reset");

        // good frames read back in order
        repeat (5) begin
            ps2_send(8'($urandom), 1'b0);
            read_check(io_map_pkg::reg_status, "status count after frame");
        end
        while (exp_codes.size() != 0) begin
            read_check(io_map_pkg::reg_kbd_data, "scan code readback");
            read_check(io_map_pkg::reg_status, "status after pop");
        end

        // bad parity adds nothing
        ps2_send(8'($urandom), 1'b0);
        ps2_send(8'($urandom), 1'b1);
        read_check(io_map_pkg::reg_status, "status after bad parity frame");
        ps2_send(8'($urandom), 1'b0);
        read_check(io_map_pkg::reg_kbd_data, "code before bad frame");
        read_check(io_map_pkg::reg_kbd_data, "code after bad frame");

        // overflow, clear, drain, then empty read
        repeat (10) ps2_send(8'($urandom), 1'b0);
        read_check(io_map_pkg::reg_status, "status after overflow");
        write_check(io_map_pkg::reg_status, 32'h2, "status write response");
        exp_ovf = 1'b0;
        read_check(io_map_pkg::reg_status, "status after overflow clear");
        while (exp_codes.size() != 0) begin
            read_check(io_map_pkg::reg_kbd_data, "kept code readback");
        end
        read_check(io_map_pkg::reg_kbd_data, "empty kbd_data read");
        read_check(io_map_pkg::reg_status, "status when empty");

        // led and switch paths
        data = $urandom;
        exp_led = data[7:0];
        write_check(io_map_pkg::reg_led, data, "led write response");
        check(32'(leds), 32'(exp_led), "leds pins");
        read_check(io_map_pkg::reg_led, "led readback");
        swt = 8'($urandom);
        exp_swt = swt;
        repeat (ps2_pkg::sync_stages + 1) step();
        read_check(io_map_pkg::reg_swt, "switch readback");

        // segment shift rebuilt by the monitor
        exp_seg = $urandom;
        shifts_before = seg_shifts;
        write_check(io_map_pkg::reg_seg, exp_seg, "seg write response");
        while (seg_shifts == shifts_before) step();
        check(32'(seg_en), 32'd1, "seg_en back high after shift");
        read_check(io_map_pkg::reg_seg, "seg readback");

        // unmapped offset
        axil_write(5'h14, $urandom, 4'hF, resp);
        check(32'(resp), 32'(io_map_pkg::resp_slverr), "unmapped write response");
        // a stray load would pull seg_en low for the whole shift
        check(32'(seg_en), 32'd1, "no shift from unmapped write");
        axil_read(5'h14, data, resp);
        check(32'(resp), 32'(io_map_pkg::resp_slverr), "unmapped read response");
        check(32'(leds), 32'(exp_led), "leds after unmapped write");
        read_check(io_map_pkg::reg_led, "led after unmapped access");
        read_check(io_map_pkg::reg_seg, "seg after unmapped access");
        read_check(io_map_pkg::reg_status, "status after unmapped access");
        read_check(io_map_pkg::reg_swt, "switch after unmapped access");

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/io_map_pkg.sv
src/ps2_pkg.sv
src/ps2_rx.sv
src/scan_fifo.sv
src/io_axil_regs.sv
src/seg_shift.sv
src/io_top.sv
tests/tb_io_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the io subsystem testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_io_top -f src.f -o sim_io_top

# keep the simulator exit code, the log is searched below
sim_status=0
./obj_dir/sim_io_top > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation finished cleanly"
